// ==== hw/dma_read_pkg.sv ====
/*
 * Shared definitions for the read DMA engine: sizes, bus identities,
 * command codes, register offsets and the register and memory bus structs
 */
package dma_read_pkg;

	// Sizes
	localparam int addr_w = 31;
	localparam int beat_w = 64;
	localparam int burst_beats = 8;
	localparam int burst_bytes = 64;
	localparam int fifo_depth = 128;
	localparam int fifo_level_w = 8;
	localparam int credit_w = 3;
	localparam int initial_credits = 2;

	// Memory bus identity
	localparam logic [3:0] fsab_did = 4'h3;
	localparam logic [3:0] fsab_subdid = 4'h1;
	localparam logic [1:0] fsab_mode_read = 2'b00;

	// Register bus identity and decode window
	localparam logic [3:0] spam_did = 4'h5;
	localparam logic [23:0] spam_addr_pfx = 24'h000100;
	localparam logic [23:0] spam_addr_mask = 24'hFFFFE0;

	typedef enum logic [1:0] {
		cmd_stop = 2'd0,
		cmd_trigger_once = 2'd1,
		cmd_autotrigger = 2'd2
	} dma_cmd_t;

	// Offsets within the 32-byte register window
	localparam logic [4:0] reg_next_start = 5'h00;
	localparam logic [4:0] reg_next_len = 5'h04;
	localparam logic [4:0] reg_command = 5'h08;
	localparam logic [4:0] reg_bytes_read = 5'h0C;
	localparam logic [4:0] reg_bytes_delivered = 5'h10;
	localparam logic [4:0] reg_curr_start = 5'h14;

	typedef struct packed {
		logic valid;
		logic r_nw;
		logic [3:0] did;
		logic [23:0] addr;
		logic [31:0] data;
	} spam_req_t;

	typedef struct packed {
		logic done;
		logic [31:0] data;
	} spam_rsp_t;

	typedef struct packed {
		logic valid;
		logic [1:0] mode;
		logic [3:0] did;
		logic [3:0] subdid;
		logic [addr_w-1:0] addr;
		logic [3:0] len;
	} fsab_req_t;

	typedef struct packed {
		logic valid;
		logic [3:0] did;
		logic [3:0] subdid;
		logic [beat_w-1:0] data;
	} fsab_rsp_t;

endpackage

// ==== hw/dma_csr_regs.sv ====
/*
 * Register bus slave for the read DMA engine: address decode,
 * next-start and next-length registers, command write strobe and read-back
 */
`timescale 1ns/100ps

module dma_csr_regs (
	input logic target_clk,
	input logic target_rst_b,
	input dma_read_pkg::spam_req_t spam_req,
	output dma_read_pkg::spam_rsp_t spam_rsp,
	output logic [dma_read_pkg::addr_w-1:0] next_start,
	output logic [dma_read_pkg::addr_w-1:0] next_len,
	output logic cmd_wr,
	output dma_read_pkg::dma_cmd_t cmd_wr_data,
	input logic [dma_read_pkg::addr_w-1:0] bytes_read,
	input logic [dma_read_pkg::addr_w-1:0] curr_start,
	input logic [dma_read_pkg::addr_w-1:0] bytes_delivered
);
	import dma_read_pkg::*;

	logic hit;
	logic wr_hit;
	logic rd_hit;
	logic [4:0] offset;
	logic [addr_w-1:0] rd_sel;
	logic [31:0] rd_mux;

	// Access belongs to us when ID and masked address both match
	assign hit = spam_req.valid && (spam_req.did == spam_did) &&
		((spam_req.addr & spam_addr_mask) == spam_addr_pfx);
	assign wr_hit = hit && !spam_req.r_nw;
	assign rd_hit = hit && spam_req.r_nw;
	assign offset = spam_req.addr[4:0];

	// Command goes straight to the control block, which registers it
	assign cmd_wr = wr_hit && (offset == reg_command);
	assign cmd_wr_data = dma_cmd_t'(spam_req.data[1:0]);

	always_ff @(posedge target_clk or negedge target_rst_b) begin
		if (!target_rst_b) begin
			next_start <= '0;
			next_len <= '0;
		end else if (wr_hit) begin
			if (offset == reg_next_start)
				next_start <= spam_req.data[addr_w-1:0];
			if (offset == reg_next_len)
				next_len <= spam_req.data[addr_w-1:0];
		end
	end

	// Unknown offsets read as zero
	always_comb begin
		case (offset)
			reg_next_start: rd_sel = next_start;
			reg_next_len: rd_sel = next_len;
			reg_bytes_read: rd_sel = bytes_read;
			reg_bytes_delivered: rd_sel = bytes_delivered;
			reg_curr_start: rd_sel = curr_start;
			default: rd_sel = '0;
		endcase
	end

	assign rd_mux = {{(32-addr_w){1'b0}}, rd_sel};

	// Done and read data one clock after the access
	always_ff @(posedge target_clk or negedge target_rst_b) begin
		if (!target_rst_b) begin
			spam_rsp <= '0;
		end else begin
			spam_rsp.done <= hit;
			spam_rsp.data <= rd_hit ? rd_mux : 32'h0;
		end
	end

endmodule

// ==== hw/dma_read_ctrl.sv ====
/*
 * Transfer control for the read DMA engine: command register, triggered
 * state, burst address tracking, pending burst and bytes-read counter
 */
`timescale 1ns/100ps

module dma_read_ctrl (
	input logic target_clk,
	input logic target_rst_b,
	input logic [dma_read_pkg::addr_w-1:0] next_start,
	input logic [dma_read_pkg::addr_w-1:0] next_len,
	input logic cmd_wr,
	input dma_read_pkg::dma_cmd_t cmd_wr_data,
	input logic req_sent,
	input logic burst_done,
	input logic almost_full,
	output logic issue_ok,
	output logic [dma_read_pkg::addr_w-1:0] next_fsab_addr,
	output logic [dma_read_pkg::addr_w-1:0] bytes_read,
	output logic [dma_read_pkg::addr_w-1:0] curr_start
);
	import dma_read_pkg::*;

	dma_cmd_t cmd_q;
	logic triggered;
	logic pending;
	logic [addr_w-1:0] end_addr;
	logic [addr_w-1:0] burst_end;
	logic start;
	logic last_done;

	// Address just past the burst in flight
	assign burst_end = next_fsab_addr + addr_w'(burst_bytes);

	assign start = !triggered &&
		((cmd_q == cmd_trigger_once) || (cmd_q == cmd_autotrigger));
	assign last_done = triggered && burst_done && (burst_end == end_addr);

	// One burst in flight at a time, held off while the FIFO is nearly full
	assign issue_ok = triggered && !pending && !almost_full;

	// A one-shot command drops back to stop when its transfer ends
	always_ff @(posedge target_clk or negedge target_rst_b) begin
		if (!target_rst_b)
			cmd_q <= cmd_stop;
		else if (cmd_wr)
			cmd_q <= cmd_wr_data;
		else if (last_done && (cmd_q == cmd_trigger_once))
			cmd_q <= cmd_stop;
	end

	always_ff @(posedge target_clk or negedge target_rst_b) begin
		if (!target_rst_b) begin
			triggered <= 1'b0;
			pending <= 1'b0;
			next_fsab_addr <= '0;
			curr_start <= '0;
			end_addr <= '0;
			bytes_read <= '0;
		end else if (start) begin
			triggered <= 1'b1;
			next_fsab_addr <= next_start;
			curr_start <= next_start;
			end_addr <= next_start + next_len;
		end else if (triggered) begin
			if (burst_done) begin
				pending <= 1'b0;
				if (last_done) begin
					// Autotrigger restarts from idle on the next cycle
					triggered <= 1'b0;
					bytes_read <= '0;
				end else begin
					next_fsab_addr <= burst_end;
					bytes_read <= bytes_read + addr_w'(burst_bytes);
				end
			end else if (req_sent) begin
				pending <= 1'b1;
			end
		end
	end

endmodule

// ==== hw/fsab_req_issue.sv ====
/*
 * Memory bus request side: credit counter and burst read request formation
 */
`timescale 1ns/100ps

module fsab_req_issue (
	input logic target_clk,
	input logic target_rst_b,
	input logic issue_ok,
	input logic [dma_read_pkg::addr_w-1:0] next_fsab_addr,
	input logic fsab_credit,
	output dma_read_pkg::fsab_req_t fsab_req,
	output logic req_sent
);
	import dma_read_pkg::*;

	logic [credit_w-1:0] credits;
	logic send;

	// No credits means no request, for as long as it takes
	assign send = issue_ok && (credits != '0);
	assign req_sent = send;

	always_comb begin
		fsab_req = '0;
		if (send) begin
			fsab_req.valid = 1'b1;
			fsab_req.mode = fsab_mode_read;
			fsab_req.did = fsab_did;
			fsab_req.subdid = fsab_subdid;
			fsab_req.addr = next_fsab_addr;
			fsab_req.len = 4'(burst_beats);
		end
	end

	// Returned credit and new request may land in the same cycle
	always_ff @(posedge target_clk or negedge target_rst_b) begin
		if (!target_rst_b)
			credits <= credit_w'(initial_credits);
		else
			credits <= credits + credit_w'(fsab_credit) - credit_w'(send);
	end

endmodule

// ==== hw/fsab_resp_collect.sv ====
/*
 * Memory bus response side: ID filter, FIFO write and per-burst beat count
 */
`timescale 1ns/100ps

module fsab_resp_collect (
	input logic target_clk,
	input logic target_rst_b,
	input dma_read_pkg::fsab_rsp_t fsab_rsp,
	output logic wr_en,
	output logic [dma_read_pkg::beat_w-1:0] wr_data,
	output logic burst_done
);
	import dma_read_pkg::*;

	logic accept;
	logic [$clog2(burst_beats)-1:0] beat_cnt;

	// Beats for other devices pass by untouched
	assign accept = fsab_rsp.valid && (fsab_rsp.did == fsab_did) &&
		(fsab_rsp.subdid == fsab_subdid);

	assign wr_en = accept;
	assign wr_data = fsab_rsp.data;

	// Counter wraps back to zero on the last beat of a burst
	always_ff @(posedge target_clk or negedge target_rst_b) begin
		if (!target_rst_b) begin
			beat_cnt <= '0;
			burst_done <= 1'b0;
		end else begin
			burst_done <= accept && (beat_cnt == burst_beats - 1);
			if (accept)
				beat_cnt <= beat_cnt + 1'b1;
		end
	end

endmodule

// ==== hw/dma_data_fifo.sv ====
/*
 * Beat FIFO between the memory responses and the consumer, with fill
 * level, almost-full hold-off, registered read port and delivery counter
 */
`timescale 1ns/100ps

module dma_data_fifo (
	input logic target_clk,
	input logic target_rst_b,
	input logic wr_en,
	input logic [dma_read_pkg::beat_w-1:0] wr_data,
	input logic request,
	output logic [dma_read_pkg::beat_w-1:0] data,
	output logic data_ready,
	output logic fifo_empty,
	output logic almost_full,
	output logic [dma_read_pkg::addr_w-1:0] bytes_delivered
);
	import dma_read_pkg::*;

	logic [beat_w-1:0] mem [fifo_depth];
	// Pointers are one bit narrower than the level
	logic [fifo_level_w-2:0] wr_ptr;
	logic [fifo_level_w-2:0] rd_ptr;
	logic [fifo_level_w-1:0] fill_level;
	logic pop;

	assign fifo_empty = (fill_level == '0);
	// Room for one more full burst
	assign almost_full = (fill_level > fifo_level_w'(fifo_depth - burst_beats));
	assign pop = request && !fifo_empty;

	always_ff @(posedge target_clk) begin
		if (wr_en)
			mem[wr_ptr] <= wr_data;
		if (pop)
			data <= mem[rd_ptr];
	end

	always_ff @(posedge target_clk or negedge target_rst_b) begin
		if (!target_rst_b) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill_level <= '0;
			data_ready <= 1'b0;
			bytes_delivered <= '0;
		end else begin
			data_ready <= pop;
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
				bytes_delivered <= bytes_delivered + addr_w'(beat_w / 8);
			end
			fill_level <= fill_level + fifo_level_w'(wr_en) - fifo_level_w'(pop);
		end
	end

endmodule

// ==== hw/dma_read_top.sv ====
/*
 * Read DMA engine top level: register slave, transfer control,
 * request issue, response collection and beat FIFO
 */
`timescale 1ns/100ps

module dma_read_top (
	input logic target_clk,
	input logic target_rst_b,
	input dma_read_pkg::spam_req_t spam_req,
	output dma_read_pkg::spam_rsp_t spam_rsp,
	output dma_read_pkg::fsab_req_t fsab_req,
	input logic fsab_credit,
	input dma_read_pkg::fsab_rsp_t fsab_rsp,
	input logic request,
	output logic [dma_read_pkg::beat_w-1:0] data,
	output logic data_ready,
	output logic fifo_empty
);
	import dma_read_pkg::*;

	logic [addr_w-1:0] next_start;
	logic [addr_w-1:0] next_len;
	logic cmd_wr;
	dma_cmd_t cmd_wr_data;
	logic [addr_w-1:0] bytes_read;
	logic [addr_w-1:0] curr_start;
	logic [addr_w-1:0] bytes_delivered;
	logic [addr_w-1:0] next_fsab_addr;
	logic issue_ok;
	logic req_sent;
	logic burst_done;
	logic almost_full;
	logic wr_en;
	logic [beat_w-1:0] wr_data;

	dma_csr_regs u_csr_regs (
		.target_clk(target_clk),
		.target_rst_b(target_rst_b),
		.spam_req(spam_req),
		.spam_rsp(spam_rsp),
		.next_start(next_start),
		.next_len(next_len),
		.cmd_wr(cmd_wr),
		.cmd_wr_data(cmd_wr_data),
		.bytes_read(bytes_read),
		.curr_start(curr_start),
		.bytes_delivered(bytes_delivered)
	);

	dma_read_ctrl u_read_ctrl (
		.target_clk(target_clk),
		.target_rst_b(target_rst_b),
		.next_start(next_start),
		.next_len(next_len),
		.cmd_wr(cmd_wr),
		.cmd_wr_data(cmd_wr_data),
		.req_sent(req_sent),
		.burst_done(burst_done),
		.almost_full(almost_full),
		.issue_ok(issue_ok),
		.next_fsab_addr(next_fsab_addr),
		.bytes_read(bytes_read),
		.curr_start(curr_start)
	);

	fsab_req_issue u_req_issue (
		.target_clk(target_clk),
		.target_rst_b(target_rst_b),
		.issue_ok(issue_ok),
		.next_fsab_addr(next_fsab_addr),
		.fsab_credit(fsab_credit),
		.fsab_req(fsab_req),
		.req_sent(req_sent)
	);

	fsab_resp_collect u_resp_collect (
		.target_clk(target_clk),
		.target_rst_b(target_rst_b),
		.fsab_rsp(fsab_rsp),
		.wr_en(wr_en),
		.wr_data(wr_data),
		.burst_done(burst_done)
	);

	dma_data_fifo u_data_fifo (
		.target_clk(target_clk),
		.target_rst_b(target_rst_b),
		.wr_en(wr_en),
		.wr_data(wr_data),
		.request(request),
		.data(data),
		.data_ready(data_ready),
		.fifo_empty(fifo_empty),
		.almost_full(almost_full),
		.bytes_delivered(bytes_delivered)
	);

endmodule

// ==== dv/dma_read_properties.sv ====
/*
 * Concurrent checks on the read DMA top level: credit gating,
 * FIFO fill bound and pops on an empty FIFO
 */
`timescale 1ns/100ps

module dma_read_properties (
	input logic target_clk,
	input logic target_rst_b,
	input logic fsab_valid,
	input logic fsab_credit,
	input logic [dma_read_pkg::fifo_level_w-1:0] fill_level,
	input logic request,
	input logic fifo_empty,
	input logic data_ready
);
	import dma_read_pkg::*;

	int fail_count = 0;
	logic [credit_w-1:0] credits_left;

	// Credits still granted by the memory side, counted at the ports
	always_ff @(posedge target_clk or negedge target_rst_b) begin
		if (!target_rst_b)
			credits_left <= credit_w'(initial_credits);
		else
			credits_left <= credits_left + credit_w'(fsab_credit) - credit_w'(fsab_valid);
	end

	credit_gate: assert property (@(posedge target_clk) disable iff (!target_rst_b)
		fsab_valid |-> (credits_left != '0))
		else begin
			fail_count++;
			$error("memory request issued with no credits left");
		end

	fill_bound: assert property (@(posedge target_clk) disable iff (!target_rst_b)
		fill_level <= fifo_level_w'(fifo_depth))
		else begin
			fail_count++;
			$error("FIFO level above its depth");
		end

	// Request on an empty FIFO must not produce a beat
	empty_pop: assert property (@(posedge target_clk) disable iff (!target_rst_b)
		(request && fifo_empty) |=> !data_ready)
		else begin
			fail_count++;
			$error("data_ready after a request on an empty FIFO");
		end

endmodule

bind dma_read_top dma_read_properties u_properties (
	.target_clk(target_clk),
	.target_rst_b(target_rst_b),
	.fsab_valid(fsab_req.valid),
	.fsab_credit(fsab_credit),
	.fill_level(u_data_fifo.fill_level),
	.request(request),
	.fifo_empty(fifo_empty),
	.data_ready(data_ready)
);

// ==== dv/dma_read_tb.sv ====
/*
 * Testbench for the read DMA engine: clock and reset, memory bus model,
 * register bus and consumer tasks, directed tests and watchdog
 */
`timescale 1ns/100ps

module dma_read_tb;
	import dma_read_pkg::*;

	logic target_clk;
	logic target_rst_b;
	spam_req_t spam_req;
	spam_rsp_t spam_rsp;
	fsab_req_t fsab_req;
	logic fsab_credit;
	fsab_rsp_t fsab_rsp;
	logic request;
	logic [beat_w-1:0] data;
	logic data_ready;
	logic fifo_empty;

	logic [31:0] lcg_state = 32'd97782;
	logic [addr_w-1:0] req_q[$];
	int req_count = 0;
	bit inject_foreign = 1'b0;
	bit hold_credits = 1'b0;
	int credits_owed = 0;
	int unsigned delivered_total = 0;

	dma_read_top u_dma_read_top (.*);

	always #50 target_clk = ~target_clk;

	function automatic int unsigned rand_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state >> 8;
	endfunction

	// Memory contents: beat address on top, its inverse below
	function automatic logic [63:0] beat_value(input logic [31:0] addr);
		return {addr, ~addr};
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected)
			abort_run($sformatf("Error at %0d ns: %s is 0x%0h, expected 0x%0h",
				$time, name, actual, expected));
	endtask

	task automatic spam_access(input logic r_nw, input logic [3:0] did, input logic [4:0] offset,
		input logic [31:0] wdata, output logic done, output logic [31:0] rdata);
		@(negedge target_clk);
		spam_req.valid = 1'b1;
		spam_req.r_nw = r_nw;
		spam_req.did = did;
		spam_req.addr = spam_addr_pfx | {19'h0, offset};
		spam_req.data = wdata;
		@(negedge target_clk);
		spam_req = '0;
		done = spam_rsp.done;
		rdata = spam_rsp.data;
		// Done lasts a single cycle
		@(negedge target_clk);
		check_value("spam_rsp.done", spam_rsp.done, 1'b0);
	endtask

	task automatic spam_write(input logic [4:0] offset, input logic [31:0] wdata);
		logic done;
		logic [31:0] rdata;
		spam_access(1'b0, spam_did, offset, wdata, done, rdata);
		check_value("spam_rsp.done", done, 1'b1);
	endtask

	task automatic spam_read(input logic [4:0] offset, input logic [31:0] expected,
		input string name);
		logic done;
		logic [31:0] rdata;
		spam_access(1'b1, spam_did, offset, 32'h0, done, rdata);
		check_value("spam_rsp.done", done, 1'b1);
		check_value(name, rdata, expected);
	endtask

	task automatic start_transfer(input logic [31:0] start, input logic [31:0] len,
		input dma_cmd_t cmd);
		spam_write(reg_next_start, start);
		spam_write(reg_next_len, len);
		spam_write(reg_command, 32'(cmd));
	endtask

	// Beat k is expected at start + 8k, wrapping every len bytes
	task automatic pop_beats(input int count, input logic [31:0] start, input logic [31:0] len);
		int waited;
		logic [31:0] addr;
		for (int idx = 0; idx < count; idx++) begin
			waited = 0;
			@(negedge target_clk);
			while (fifo_empty) begin
				waited++;
				if (waited > 1000)
					abort_run("Timeout: no beat arrived in the FIFO");
				@(negedge target_clk);
			end
			request = 1'b1;
			@(negedge target_clk);
			request = 1'b0;
			check_value("data_ready", data_ready, 1'b1);
			addr = start + (idx * 8) % len;
			check_value("data", data, beat_value(addr));
			delivered_total += 8;
			repeat (rand_next() % 3) @(negedge target_clk);
		end
	endtask

	task automatic wait_quiet(input int quiet);
		int last;
		int still;
		int total;
		last = req_count;
		still = 0;
		total = 0;
		while (still < quiet) begin
			@(negedge target_clk);
			total++;
			if (total > 5000)
				abort_run("Timeout: memory request traffic never settled");
			if (req_count != last) begin
				last = req_count;
				still = 0;
			end else begin
				still++;
			end
		end
	endtask

	// Request strobe is combinational, sampled mid-cycle
	always @(negedge target_clk) begin
		if (target_rst_b && fsab_req.valid) begin
			check_value("fsab_req.len", fsab_req.len, 4'd8);
			check_value("fsab_req.mode", fsab_req.mode, fsab_mode_read);
			check_value("fsab_req.did", fsab_req.did, fsab_did);
			check_value("fsab_req.subdid", fsab_req.subdid, fsab_subdid);
			req_q.push_back(fsab_req.addr);
			req_count++;
		end
	end

	initial begin : memory_model
		logic [31:0] base;
		fsab_rsp = '0;
		forever begin
			@(negedge target_clk);
			if (req_q.size() != 0) begin
				base = 32'(req_q.pop_front());
				repeat (rand_next() % 6) @(negedge target_clk);
				for (int beat = 0; beat < 8; beat++) begin
					if (inject_foreign && (rand_next() % 2 == 1)) begin
						fsab_rsp.valid = 1'b1;
						fsab_rsp.did = 4'h9;
						fsab_rsp.subdid = fsab_subdid;
						fsab_rsp.data = {rand_next(), rand_next()};
						@(negedge target_clk);
					end
					fsab_rsp.valid = 1'b1;
					fsab_rsp.did = fsab_did;
					fsab_rsp.subdid = fsab_subdid;
					fsab_rsp.data = beat_value(base + 8 * beat);
					@(negedge target_clk);
				end
				fsab_rsp = '0;
				credits_owed++;
			end
		end
	end

	// One credit back per finished burst, unless held
	initial begin : credit_return
		fsab_credit = 1'b0;
		forever begin
			@(negedge target_clk);
			fsab_credit = 1'b0;
			if (!hold_credits && credits_owed > 0) begin
				repeat (rand_next() % 4) @(negedge target_clk);
				fsab_credit = 1'b1;
				credits_owed--;
			end
		end
	end

	task automatic reset_defaults();
		check_value("fifo_empty", fifo_empty, 1'b1);
		check_value("data_ready", data_ready, 1'b0);
		check_value("fsab_req.valid", fsab_req.valid, 1'b0);
		// Request on an empty FIFO is ignored
		@(negedge target_clk);
		request = 1'b1;
		@(negedge target_clk);
		request = 1'b0;
		check_value("data_ready", data_ready, 1'b0);
		check_value("fifo_empty", fifo_empty, 1'b1);
		spam_read(reg_bytes_read, 32'h0, "bytes_read");
		spam_read(reg_bytes_delivered, 32'h0, "bytes_delivered");
	endtask

	task automatic register_access();
		logic done;
		logic [31:0] rdata;
		start_transfer(32'h1000, 32'h100, cmd_trigger_once);
		spam_read(reg_next_len, 32'h100, "next_len");
		spam_read(reg_curr_start, 32'h1000, "curr_start");
		spam_read(5'h1C, 32'h0, "unknown register");
		spam_access(1'b1, 4'h6, reg_curr_start, 32'h0, done, rdata);
		check_value("spam_rsp.done", done, 1'b0);
	endtask

	// Continues the transfer that register_access started
	task automatic single_transfer();
		pop_beats(32, 32'h1000, 32'h100);
		wait_quiet(60);
		check_value("fsab_req count", req_count, 4);
		spam_read(reg_bytes_delivered, delivered_total, "bytes_delivered");
		spam_read(reg_bytes_read, 32'h0, "bytes_read");
	endtask

	task automatic foreign_id_filter();
		int base;
		base = req_count;
		inject_foreign = 1'b1;
		start_transfer(32'h2000, 32'h100, cmd_trigger_once);
		pop_beats(32, 32'h2000, 32'h100);
		wait_quiet(60);
		inject_foreign = 1'b0;
		check_value("fsab_req count", req_count - base, 4);
		check_value("fifo_empty", fifo_empty, 1'b1);
		spam_read(reg_bytes_delivered, delivered_total, "bytes_delivered");
	endtask

	// Two credits carry two bursts, then issue waits for a returned credit
	task automatic credit_stall();
		int base;
		base = req_count;
		hold_credits = 1'b1;
		start_transfer(32'h6000, 32'h100, cmd_trigger_once);
		wait_quiet(60);
		check_value("fsab_req count", req_count - base, 2);
		hold_credits = 1'b0;
		pop_beats(32, 32'h6000, 32'h100);
		wait_quiet(60);
		check_value("fsab_req count", req_count - base, 4);
		spam_read(reg_bytes_delivered, delivered_total, "bytes_delivered");
	endtask

	task automatic fifo_backpressure();
		int base;
		base = req_count;
		start_transfer(32'h8000, 32'h800, cmd_trigger_once);
		wait_quiet(60);
		// 15 bursts leave 120 entries, the 16th pushes past the hold-off mark
		check_value("fsab_req count", req_count - base, 16);
		check_value("fifo_empty", fifo_empty, 1'b0);
		spam_read(reg_bytes_read, 32'h400, "bytes_read");
		pop_beats(256, 32'h8000, 32'h800);
		wait_quiet(60);
		check_value("fsab_req count", req_count - base, 32);
		spam_read(reg_bytes_delivered, delivered_total, "bytes_delivered");
	endtask

	task automatic autotrigger_passes();
		int base;
		int waited;
		base = req_count;
		waited = 0;
		start_transfer(32'h4000, 32'h80, cmd_autotrigger);
		// Third request opens the second pass
		while (req_count - base < 3) begin
			waited++;
			if (waited > 500)
				abort_run("Timeout: autotrigger never started a second pass");
			@(negedge target_clk);
		end
		spam_write(reg_command, 32'(cmd_stop));
		pop_beats(32, 32'h4000, 32'h80);
		wait_quiet(60);
		check_value("fsab_req count", req_count - base, 4);
		check_value("fifo_empty", fifo_empty, 1'b1);
		spam_read(reg_curr_start, 32'h4000, "curr_start");
	endtask

	initial begin : watchdog
		int limit_cycles;
		// Rough cycle counts per test, doubled
		limit_cycles = 2 * (40 + 60 + 800 + 900 + 900 + 4200 + 900);
		repeat (limit_cycles) @(posedge target_clk);
		abort_run("Timeout: watchdog expired before the tests finished");
	end

	initial begin
		target_clk = 1'b0;
		target_rst_b = 1'b0;
		spam_req = '0;
		request = 1'b0;
		repeat (16) @(posedge target_clk);
		@(negedge target_clk);
		target_rst_b = 1'b1;
		reset_defaults();
		register_access();
		single_transfer();
		foreign_id_filter();
		credit_stall();
		fifo_backpressure();
		autotrigger_passes();
		if (u_dma_read_top.u_properties.fail_count == 0) begin
			$display("Simulation completed successfully");
			$finish;
		end else begin
			abort_run("A concurrent assertion on the DUT failed");
		end
	end

endmodule

// ==== flist.f ====
hw/dma_read_pkg.sv
hw/dma_csr_regs.sv
hw/dma_read_ctrl.sv
hw/fsab_req_issue.sv
hw/fsab_resp_collect.sv
hw/dma_data_fifo.sv
hw/dma_read_top.sv
dv/dma_read_properties.sv
dv/dma_read_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the read DMA testbench with Verilator, run it, and search the log

cd "$(dirname "$0")" || exit 1
log=sim.log

rm -rf obj_dir "$log"

if ! verilator --binary --timing --assert -Wno-fatal \
	--top-module dma_read_tb -f flist.f -o sim_dma_read; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_dma_read > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
	echo "Simulator exited with status $status"
fi

if grep -q "Simulation completed successfully" "$log"; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi
